// ==== Bender.yml ====
package:
  name: kbd_controller

sources:
  - src/kbd_pkg.sv
  - src/ps2_frame_rx.sv
  - src/scan_code_decoder.sv
  - src/kbd_gray_fifo.sv
  - src/kbd_core_ctrl.sv
  - src/kbd_controller_top.sv
  - target: test
    files:
      - testbench/kbd_checker.sv
      - testbench/kbd_properties.sv
      - testbench/kbd_controller_tb.sv

// ==== src/kbd_controller_top.sv ====
`timescale 1ns/100ps
module kbd_controller_top
  import kbd_pkg::*;
(
  input  logic        kbd_clk,
  input  logic        kbd_data,
  input  logic        core_clk,
  input  logic        arst_n,
  input  logic        scan_en,
  input  logic        out_ready,
  input  logic        stat_clear,
  output logic        out_valid,
  output kbd_entry_u  out_entry,
  output kbd_status_t status
);

  ps2_frame_t frame;
  logic       wr_en;
  logic       wr_full;
  kbd_entry_u wr_data;
  logic       rd_en;
  logic       rd_empty;
  kbd_entry_u rd_data;

  // kbd_clk domain front end
  ps2_frame_rx u_frame_rx (
    .kbd_clk  (kbd_clk),
    .arst_n   (arst_n),
    .kbd_data (kbd_data),
    .scan_en  (scan_en),
    .frame    (frame)
  );

  scan_code_decoder u_decoder (
    .kbd_clk (kbd_clk),
    .arst_n  (arst_n),
    .frame   (frame),
    .wr_full (wr_full),
    .wr_en   (wr_en),
    .wr_data (wr_data)
  );

  // crossing into core_clk
  kbd_gray_fifo u_fifo (
    .kbd_clk  (kbd_clk),
    .core_clk (core_clk),
    .arst_n   (arst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .rd_en    (rd_en),
    .wr_full  (wr_full),
    .rd_empty (rd_empty),
    .rd_data  (rd_data)
  );

  kbd_core_ctrl u_core_ctrl (
    .core_clk   (core_clk),
    .arst_n     (arst_n),
    .rd_empty   (rd_empty),
    .rd_data    (rd_data),
    .out_ready  (out_ready),
    .stat_clear (stat_clear),
    .rd_en      (rd_en),
    .out_valid  (out_valid),
    .out_entry  (out_entry),
    .status     (status)
  );

endmodule

// ==== src/kbd_core_ctrl.sv ====
`timescale 1ns/100ps
module kbd_core_ctrl
  import kbd_pkg::*;
(
  input  logic        core_clk,
  input  logic        arst_n,
  input  logic        rd_empty,
  input  kbd_entry_u  rd_data,
  input  logic        out_ready,
  input  logic        stat_clear,
  output logic        rd_en,
  output logic        out_valid,
  output kbd_entry_u  out_entry,
  output kbd_status_t status
);

  logic transfer;
  logic load;

  assign transfer = out_valid & out_ready;
  // refill when the register is free or drains this cycle
  assign load     = ~rd_empty & (~out_valid | transfer);
  assign rd_en    = load;

  always_ff @(posedge core_clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else if (load) begin
      out_valid <= 1'b1;
    end else if (transfer) begin
      out_valid <= 1'b0;
    end
  end

  // held while stalled
  always_ff @(posedge core_clk) begin
    if (load) begin
      out_entry <= rd_data;
    end
  end

  // counters saturate at 255, clear wins over a transfer
  always_ff @(posedge core_clk or negedge arst_n) begin
    if (!arst_n) begin
      status <= '0;
    end else if (stat_clear) begin
      status <= '0;
    end else if (transfer) begin
      // kind sits at the same bit in both views
      if (out_entry.key.kind) begin
        if (status.err_count != 8'hFF) begin
          status.err_count <= status.err_count + 8'd1;
        end
      end else begin
        if (status.key_count != 8'hFF) begin
          status.key_count <= status.key_count + 8'd1;
        end
      end
    end
  end

endmodule

// ==== src/kbd_gray_fifo.sv ====
`timescale 1ns/100ps
module kbd_gray_fifo
  import kbd_pkg::*;
(
  input  logic       kbd_clk,
  input  logic       core_clk,
  input  logic       arst_n,
  input  logic       wr_en,
  input  kbd_entry_u wr_data,
  input  logic       rd_en,
  output logic       wr_full,
  output logic       rd_empty,
  output kbd_entry_u rd_data
);

  kbd_entry_u       mem [fifo_depth];
  logic [fifo_aw:0] wr_bin;
  logic [fifo_aw:0] wr_bin_next;
  logic [fifo_aw:0] wr_gray;
  logic [fifo_aw:0] rd_bin;
  logic [fifo_aw:0] rd_bin_next;
  logic [fifo_aw:0] rd_gray;
  // gray pointers seen from the other side
  logic [fifo_aw:0] rd_gray_s1;
  logic [fifo_aw:0] rd_gray_s2;
  logic [fifo_aw:0] wr_gray_s1;
  logic [fifo_aw:0] wr_gray_s2;
  logic             wr_push;
  logic             rd_pop;

  assign wr_push     = wr_en & ~wr_full;
  assign rd_pop      = rd_en & ~rd_empty;
  assign wr_bin_next = wr_bin + 1'b1;
  assign rd_bin_next = rd_bin + 1'b1;

  // write side in kbd_clk
  always_ff @(posedge kbd_clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_bin  <= '0;
      wr_gray <= '0;
    end else if (wr_push) begin
      wr_bin  <= wr_bin_next;
      wr_gray <= wr_bin_next ^ (wr_bin_next >> 1);
    end
  end

  always_ff @(posedge kbd_clk) begin
    if (wr_push) begin
      mem[wr_bin[fifo_aw-1:0]] <= wr_data;
    end
  end

  always_ff @(posedge kbd_clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_gray_s1 <= '0;
      rd_gray_s2 <= '0;
    end else begin
      rd_gray_s1 <= rd_gray;
      rd_gray_s2 <= rd_gray_s1;
    end
  end

  // full when the top two gray bits differ and the rest match
  assign wr_full = (wr_gray == {~rd_gray_s2[fifo_aw:fifo_aw-1], rd_gray_s2[fifo_aw-2:0]});

  // read side in core_clk
  always_ff @(posedge core_clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_bin  <= '0;
      rd_gray <= '0;
    end else if (rd_pop) begin
      rd_bin  <= rd_bin_next;
      rd_gray <= rd_bin_next ^ (rd_bin_next >> 1);
    end
  end

  always_ff @(posedge core_clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_gray_s1 <= '0;
      wr_gray_s2 <= '0;
    end else begin
      wr_gray_s1 <= wr_gray;
      wr_gray_s2 <= wr_gray_s1;
    end
  end

  assign rd_empty = (rd_gray == wr_gray_s2);
  // head entry, valid whenever rd_empty is low
  assign rd_data  = mem[rd_bin[fifo_aw-1:0]];

endmodule

// ==== src/kbd_pkg.sv ====
package kbd_pkg;

  // event FIFO geometry
  localparam int fifo_depth = 4;
  localparam int fifo_aw    = 2;

  // scan code prefix bytes
  localparam logic [7:0] code_ext = 8'hE0;
  localparam logic [7:0] code_rel = 8'hF0;

  // key view of a FIFO entry
  typedef struct packed {
    logic       kind;       // 0 for a key event
    logic       lost;       // entries were dropped before this one
    logic       released;   // break code seen (F0 prefix)
    logic       extended;   // E0 prefix seen
    logic [7:0] code;
  } kbd_key_t;

  // error view of a FIFO entry
  typedef struct packed {
    logic       kind;       // 1 for an error report
    logic       parity_err;
    logic       stop_err;
    logic       spare;
    logic [7:0] raw;        // byte as it was received
  } kbd_err_t;

  // one FIFO word, bit 11 picks the view
  typedef union packed {
    kbd_key_t key;
    kbd_err_t err;
  } kbd_entry_u;

  // result of one received PS/2 frame
  typedef struct packed {
    logic [7:0] data;
    logic       parity_err;
    logic       stop_err;
    logic       strobe;
  } ps2_frame_t;

  // core side counters
  typedef struct packed {
    logic [7:0] key_count;
    logic [7:0] err_count;
  } kbd_status_t;

endpackage

// ==== src/ps2_frame_rx.sv ====
`timescale 1ns/100ps
module ps2_frame_rx
  import kbd_pkg::*;
(
  input  logic       kbd_clk,
  input  logic       arst_n,
  input  logic       kbd_data,
  input  logic       scan_en,
  output ps2_frame_t frame
);

  logic [1:0] rst_sync;
  logic       kbd_rst_n;
  logic [1:0] scan_en_sync;
  logic [3:0] bit_cnt;
  logic [8:0] shift_q;
  logic       strobe_q;
  logic [7:0] data_q;
  logic       parity_err_q;
  logic       stop_err_q;

  // reset asserts at once and releases two kbd_clk edges later
  always_ff @(posedge kbd_clk or negedge arst_n) begin
    if (!arst_n) begin
      rst_sync <= 2'b00;
    end else begin
      rst_sync <= {rst_sync[0], 1'b1};
    end
  end
  assign kbd_rst_n = rst_sync[1];

  // scan_en comes from the core domain
  always_ff @(posedge kbd_clk or negedge kbd_rst_n) begin
    if (!kbd_rst_n) begin
      scan_en_sync <= 2'b00;
    end else begin
      scan_en_sync <= {scan_en_sync[0], scan_en};
    end
  end

  // 0 is idle, 1..9 take data and parity, 10 takes the stop bit
  always_ff @(posedge kbd_clk or negedge kbd_rst_n) begin
    if (!kbd_rst_n) begin
      bit_cnt  <= 4'd0;
      strobe_q <= 1'b0;
    end else begin
      strobe_q <= 1'b0;
      if (bit_cnt == 4'd0) begin
        // hunt for a low start bit, only while scanning
        if (scan_en_sync[1] && !kbd_data) begin
          bit_cnt <= 4'd1;
        end
      end else if (bit_cnt == 4'd10) begin
        bit_cnt  <= 4'd0;
        strobe_q <= 1'b1;
      end else begin
        bit_cnt <= bit_cnt + 4'd1;
      end
    end
  end

  // lsb first, so shift in from the top
  always_ff @(posedge kbd_clk) begin
    if ((bit_cnt != 4'd0) && (bit_cnt != 4'd10)) begin
      shift_q <= {kbd_data, shift_q[8:1]};
    end
    if (bit_cnt == 4'd10) begin
      data_q       <= shift_q[7:0];
      // odd parity over data plus parity bit
      parity_err_q <= ~(^shift_q);
      stop_err_q   <= ~kbd_data;
    end
  end

  assign frame = '{data: data_q, parity_err: parity_err_q, stop_err: stop_err_q,
                   strobe: strobe_q};

endmodule

// ==== src/scan_code_decoder.sv ====
`timescale 1ns/100ps
module scan_code_decoder
  import kbd_pkg::*;
(
  input  logic       kbd_clk,
  input  logic       arst_n,
  input  ps2_frame_t frame,
  input  logic       wr_full,
  output logic       wr_en,
  output kbd_entry_u wr_data
);

  logic       ext_pending;
  logic       rel_pending;
  logic       lost;
  logic       is_err;
  logic       is_prefix;
  kbd_entry_u entry_next;

  assign is_err    = frame.parity_err | frame.stop_err;
  assign is_prefix = (frame.data == code_ext) || (frame.data == code_rel);

  // build the entry for the current frame in one of its two views
  always_comb begin
    if (is_err) begin
      entry_next.err = '{kind: 1'b1, parity_err: frame.parity_err,
                         stop_err: frame.stop_err, spare: 1'b0, raw: frame.data};
    end else begin
      entry_next.key = '{kind: 1'b0, lost: lost, released: rel_pending,
                         extended: ext_pending, code: frame.data};
    end
  end

  // prefix flags, write strobe and sticky loss
  always_ff @(posedge kbd_clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_en       <= 1'b0;
      ext_pending <= 1'b0;
      rel_pending <= 1'b0;
      lost        <= 1'b0;
    end else begin
      wr_en <= 1'b0;
      if (frame.strobe) begin
        if (is_err || !is_prefix) begin
          // error or final byte ends the sequence
          ext_pending <= 1'b0;
          rel_pending <= 1'b0;
          if (wr_full) begin
            lost <= 1'b1;
          end else begin
            wr_en <= 1'b1;
            // lost rides only on a key entry
            if (!is_err) begin
              lost <= 1'b0;
            end
          end
        end else if (frame.data == code_ext) begin
          ext_pending <= 1'b1;
        end else begin
          rel_pending <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge kbd_clk) begin
    if (frame.strobe) begin
      wr_data <= entry_next;
    end
  end

endmodule

// ==== tb.f ====
src/kbd_pkg.sv
src/ps2_frame_rx.sv
src/scan_code_decoder.sv
src/kbd_gray_fifo.sv
src/kbd_core_ctrl.sv
src/kbd_controller_top.sv
testbench/kbd_checker.sv
testbench/kbd_properties.sv
testbench/kbd_controller_tb.sv

// ==== testbench/kbd_checker.sv ====
`timescale 1ns/100ps
module kbd_checker
  import kbd_pkg::*;
(
  input  logic        core_clk,
  input  logic        arst_n,
  input  logic        out_valid,
  input  logic        out_ready,
  input  kbd_entry_u  out_entry,
  input  kbd_status_t status
);

  kbd_entry_u exp_q[$];
  string      name_q[$];
  kbd_entry_u want;
  string      want_name;
  int         errors = 0;

  task automatic expect_entry(input string name, input kbd_entry_u value);
    exp_q.push_back(value);
    name_q.push_back(name);
  endtask

  function automatic int pending_count();
    return exp_q.size();
  endfunction

  // a transfer happens on a rising edge with valid and ready both high
  always @(posedge core_clk) begin
    if (arst_n && out_valid && out_ready) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("entry %h was transferred but none was expected", out_entry);
      end else begin
        want      = exp_q.pop_front();
        want_name = name_q.pop_front();
        if (out_entry !== want) begin
          errors++;
          $display("Fail %s: expected %h actual %h", want_name, want, out_entry);
        end
      end
    end
  end

  task automatic check_status(input string name, input int want_keys, input int want_errs);
    if (status.key_count !== want_keys[7:0]) begin
      errors++;
      $display("Fail %s key_count: expected %0d actual %0d", name, want_keys,
               status.key_count);
    end
    if (status.err_count !== want_errs[7:0]) begin
      errors++;
      $display("Fail %s err_count: expected %0d actual %0d", name, want_errs,
               status.err_count);
    end
  endtask

  task automatic report_leftover();
    if (exp_q.size() != 0) begin
      errors++;
      $display("%0d expected entries never came out, the first from %s", exp_q.size(),
               name_q[0]);
    end
  endtask

endmodule

// ==== testbench/kbd_controller_tb.sv ====
`timescale 1ns/100ps
module kbd_controller_tb
  import kbd_pkg::*;
;

  logic        kbd_clk = 1'b0;
  logic        core_clk = 1'b0;
  logic        kbd_data;
  logic        arst_n;
  logic        scan_en;
  logic        out_ready;
  logic        stat_clear;
  logic        out_valid;
  kbd_entry_u  out_entry;
  kbd_status_t status;

  // one word per frame: byte, inject, stall hint, test id
  logic [19:0] vectors [0:31];
  logic [7:0]  frame_byte;
  logic [3:0]  inject;
  logic [3:0]  hint;
  logic [3:0]  test_id;
  integer      seed = 94;
  logic        hold_ready = 1'b0;
  // decoder state as the testbench expects it
  logic        ext_flag = 1'b0;
  logic        rel_flag = 1'b0;
  logic        lost_flag = 1'b0;
  int          held = 0;
  int          exp_keys = 0;
  int          exp_errs = 0;
  int          tb_errors = 0;
  int          nframes = 0;
  int          kbd_cycles = 0;
  int          cycle_limit = 0;
  int          idx;

  always #50 kbd_clk = ~kbd_clk;
  always #15 core_clk = ~core_clk;

  kbd_controller_top DUT (
    .kbd_clk    (kbd_clk),
    .kbd_data   (kbd_data),
    .core_clk   (core_clk),
    .arst_n     (arst_n),
    .scan_en    (scan_en),
    .out_ready  (out_ready),
    .stat_clear (stat_clear),
    .out_valid  (out_valid),
    .out_entry  (out_entry),
    .status     (status)
  );

  kbd_checker u_checker (
    .core_clk  (core_clk),
    .arst_n    (arst_n),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_entry (out_entry),
    .status    (status)
  );

  // handshake side on the core, write side on the FIFO
  bind kbd_core_ctrl kbd_properties u_core_props (
    .clk (core_clk), .arst_n (arst_n), .req (rd_en), .req_blocked (rd_empty),
    .out_valid (out_valid), .out_ready (out_ready), .out_entry (out_entry)
  );
  bind kbd_gray_fifo kbd_properties u_fifo_props (
    .clk (kbd_clk), .arst_n (arst_n), .req (wr_en), .req_blocked (wr_full),
    .out_valid (1'b0), .out_ready (1'b0), .out_entry (wr_data)
  );

  // random stalls, or a solid stall for back-pressure frames
  always @(negedge core_clk) begin
    if (hold_ready) begin
      out_ready <= 1'b0;
    end else begin
      out_ready <= ($random(seed) & 3) != 0;
    end
  end

  function automatic string test_label(input logic [3:0] id);
    case (id)
      4'd1:    return "plain_codes";
      4'd2:    return "prefixes";
      4'd3:    return "frame_errors";
      4'd4:    return "backpressure";
      4'd5:    return "scan_enable";
      default: return "unnamed";
    endcase
  endfunction

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge kbd_clk);
      kbd_data <= 1'b1;
    end
  endtask

  // start, 8 data bits lsb first, odd parity, stop
  task automatic send_frame(input logic [7:0] value, input logic [3:0] code);
    logic [10:0] bits;
    int          i;
    bits = {code != 4'd2, (~(^value)) ^ (code == 4'd1), value, 1'b0};
    for (i = 0; i < 11; i++) begin
      @(negedge kbd_clk);
      kbd_data <= bits[i];
    end
  endtask

  // FIFO plus output register hold fifo_depth + 1 entries under a stall
  task automatic store_entry(input kbd_entry_u entry, input string name, input logic stalled);
    if (stalled && held == fifo_depth + 1) begin
      lost_flag = 1'b1;
    end else begin
      u_checker.expect_entry(name, entry);
      if (stalled) begin
        held++;
      end
      if (entry.key.kind) begin
        exp_errs++;
      end else begin
        exp_keys++;
        lost_flag = 1'b0;
      end
    end
  endtask

  task automatic model_frame(input logic [7:0] value, input logic [3:0] code,
                             input logic [3:0] mode, input string name);
    kbd_entry_u entry;
    // scan disabled frames leave no trace
    if (mode != 4'd2) begin
      if (code != 4'd0) begin
        entry.err = '{kind: 1'b1, parity_err: code == 4'd1, stop_err: code == 4'd2,
                      spare: 1'b0, raw: value};
        ext_flag = 1'b0;
        rel_flag = 1'b0;
        store_entry(entry, name, mode == 4'd1);
      end else if (value == code_ext) begin
        ext_flag = 1'b1;
      end else if (value == code_rel) begin
        rel_flag = 1'b1;
      end else begin
        entry.key = '{kind: 1'b0, lost: lost_flag, released: rel_flag,
                      extended: ext_flag, code: value};
        ext_flag = 1'b0;
        rel_flag = 1'b0;
        store_entry(entry, name, mode == 4'd1);
      end
    end
  endtask

  task automatic finish_run();
    int total;
    u_checker.report_leftover();
    total = u_checker.errors + tb_errors + DUT.u_core_ctrl.u_core_props.fails +
            DUT.u_fifo.u_fifo_props.fails;
    $display("errors: checker %0d, testbench %0d, assertions %0d, total %0d",
             u_checker.errors, tb_errors,
             DUT.u_core_ctrl.u_core_props.fails + DUT.u_fifo.u_fifo_props.fails, total);
    if (total == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  endtask

  // limit grows with the number of frames in the data file
  always @(posedge kbd_clk) begin
    kbd_cycles++;
    if (cycle_limit != 0 && kbd_cycles >= cycle_limit) begin
      $display("run timed out after %0d kbd_clk cycles", kbd_cycles);
      tb_errors++;
      finish_run();
    end
  end

  initial begin
    kbd_data   = 1'b1;
    arst_n     = 1'b0;
    scan_en    = 1'b1;
    out_ready  = 1'b0;
    stat_clear = 1'b0;
    for (idx = 0; idx < 32; idx++) begin
      vectors[idx] = 'x;
    end
    $readmemh("testbench/kbd_testdata.txt", vectors);
    while (nframes < 32 && !$isunknown(vectors[nframes])) begin
      nframes++;
    end
    cycle_limit = nframes * 11 + 300;
    repeat (4) @(negedge kbd_clk);
    arst_n <= 1'b1;
    // reset release and scan_en sync settle
    idle_cycles(4);
    for (idx = 0; idx < nframes; idx++) begin
      {frame_byte, inject, hint, test_id} = vectors[idx];
      // a stall starts from an empty pipe
      if (hint == 4'd1 && !hold_ready) begin
        while (u_checker.pending_count() != 0) begin
          idle_cycles(1);
        end
      end
      hold_ready <= (hint == 4'd1);
      if (hint != 4'd1) begin
        held = 0;
      end
      scan_en <= (hint != 4'd2);
      model_frame(frame_byte, inject, hint, test_label(test_id));
      idle_cycles(3);
      send_frame(frame_byte, inject);
    end
    idle_cycles(2);
    while (u_checker.pending_count() != 0) begin
      @(negedge core_clk);
    end
    u_checker.check_status("status_totals", exp_keys, exp_errs);
    @(negedge core_clk);
    stat_clear <= 1'b1;
    @(negedge core_clk);
    stat_clear <= 1'b0;
    u_checker.check_status("stat_clear", 0, 0);
    finish_run();
  end

endmodule

// ==== testbench/kbd_properties.sv ====
`timescale 1ns/100ps
module kbd_properties
  import kbd_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,
  input  logic       req,
  input  logic       req_blocked,
  input  logic       out_valid,
  input  logic       out_ready,
  input  kbd_entry_u out_entry
);

  // failed assertions, read by the testbench top
  int fails = 0;

  // a stalled entry stays put until the consumer takes it
  assert property (@(posedge clk) disable iff (!arst_n)
    out_valid && !out_ready |=> $stable(out_entry))
  else begin
    fails++;
    $error("output entry changed while stalled");
  end

  // no pop from an empty FIFO, no push into a full one
  assert property (@(posedge clk) disable iff (!arst_n) !(req && req_blocked))
  else begin
    fails++;
    $error("FIFO access while blocked");
  end

  assert property (@(posedge clk) !arst_n |-> !out_valid)
  else begin
    fails++;
    $error("out_valid high during reset");
  end

endmodule

// ==== testbench/kbd_testdata.txt ====
// hex BBIHT per frame: BB byte, I inject (0 none, 1 parity, 2 stop),
// H stall hint (0 random ready, 1 ready held low, 2 scan off), T test id
1C001
32001
F0002
1C002
E0002
75002
E0002
F0002
6B002
E0003
33103
2D003
F0003
44203
16014
1E014
26014
25014
2E014
36014
3D004
15025
24005
